//--- src/tcp_pkg.sv
package tcp_pkg;

  ///////////////////////////////////////////////////////////////////////
  // header fields
  ///////////////////////////////////////////////////////////////////////

  typedef logic [31:0] seq_t;  // seq or ack number
  typedef logic [15:0] port_t;

  // msb first, same order as the low six bits on the wire
  typedef struct packed {
    logic urg;
    logic ack;
    logic psh;
    logic rst;
    logic syn;
    logic fin;
  } tcp_flags_t;

  localparam tcp_flags_t FLAG_FIN = 6'b000001;
  localparam tcp_flags_t FLAG_SYN = 6'b000010;
  localparam tcp_flags_t FLAG_RST = 6'b000100;
  localparam tcp_flags_t FLAG_ACK = 6'b010000;

  // 102 bits, no options and no payload
  typedef struct packed {
    port_t      src;
    port_t      dst;
    seq_t       seq;
    seq_t       ack;
    tcp_flags_t flags;
  } tcp_seg_t;

  ///////////////////////////////////////////////////////////////////////
  // receive events and connection status
  ///////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic syn;         // bare syn to the local port
    logic syn_ack_ok;  // syn-ack acking our syn
    logic ack_ok;      // ack closing the 3-way handshake
    logic fin;
    logic rst;
    logic ack_any;     // pure ack, numbers not checked
    logic fin_ack;
  } rx_evt_t;

  typedef enum logic [2:0] {
    conn_closed,
    conn_listening,
    conn_connecting,
    conn_connected,
    conn_disconnecting
  } conn_status_t;

  localparam int TIMEOUT_MS_DEFAULT  = 1000;
  localparam int QUEUE_DEPTH_DEFAULT = 4;

endpackage : tcp_pkg

//--- src/tcp_rx_filter.sv
module tcp_rx_filter (
  input  logic              rx_val,
  input  tcp_pkg::tcp_seg_t rx_seg,
  input  tcp_pkg::port_t    loc_port,
  input  tcp_pkg::port_t    rem_port,
  input  tcp_pkg::seq_t     loc_seq,
  input  tcp_pkg::seq_t     rem_seq,
  output tcp_pkg::rx_evt_t  rx_evt
);
  import tcp_pkg::*;

  logic dst_ok;   // addressed to our port
  logic conn_ok;  // both ports belong to the live connection
  logic seq_ok;
  logic ack_ok;

  assign dst_ok  = rx_val && (rx_seg.dst == loc_port);
  assign conn_ok = dst_ok && (rx_seg.src == rem_port);
  assign seq_ok  = (rx_seg.seq == rem_seq);
  assign ack_ok  = (rx_seg.ack == loc_seq);

  always_comb begin
    // opening a connection, remote port not known yet
    rx_evt.syn = dst_ok && (rx_seg.flags == FLAG_SYN);

    // active open, peer must ack our isn + 1
    rx_evt.syn_ack_ok = conn_ok && (rx_seg.flags == (FLAG_SYN | FLAG_ACK)) && ack_ok;

    // last leg of the passive open
    rx_evt.ack_ok = conn_ok && (rx_seg.flags == FLAG_ACK) && seq_ok && ack_ok;

    ///////////////////////////////////////////////////////////////////////
    // closing
    ///////////////////////////////////////////////////////////////////////
    rx_evt.fin     = conn_ok && rx_seg.flags.fin;
    rx_evt.rst     = conn_ok && rx_seg.flags.rst;
    rx_evt.ack_any = conn_ok && (rx_seg.flags == FLAG_ACK);
    rx_evt.fin_ack = conn_ok && (rx_seg.flags == (FLAG_FIN | FLAG_ACK));
  end

endmodule : tcp_rx_filter

//--- src/tcp_conn_timer.sv
module tcp_conn_timer #(
  parameter int TIMEOUT_MS = tcp_pkg::TIMEOUT_MS_DEFAULT
) (
  input  logic clk,
  input  logic fsm_rst,
  input  logic run,
  input  logic tick_ms,
  output logic timeout
);

  localparam int CW = $clog2(TIMEOUT_MS + 1);

  logic [CW-1:0] tick_cnt;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tick_cnt <= '0;
      timeout  <= 1'b0;
    end else begin
      timeout <= 1'b0;  // single-cycle pulse
      if (!run) begin
        tick_cnt <= '0;  // restart with each handshake
      end else if (tick_ms) begin
        if (tick_cnt == CW'(TIMEOUT_MS - 1)) begin
          timeout  <= 1'b1;
          tick_cnt <= '0;
        end else begin
          tick_cnt <= tick_cnt + 1'b1;
        end
      end
    end
  end

endmodule : tcp_conn_timer

//--- src/tcp_conn_ctrl.sv
module tcp_conn_ctrl (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  listen,
  input  logic                  connect,
  input  logic                  disconnect,
  input  tcp_pkg::port_t        loc_port,
  input  tcp_pkg::port_t        rem_port,
  input  tcp_pkg::seq_t         isn,
  input  tcp_pkg::tcp_seg_t     rx_seg,
  input  tcp_pkg::rx_evt_t      rx_evt,
  input  logic                  timeout,
  input  logic                  full,
  output logic                  tmr_run,
  output logic                  push,
  output tcp_pkg::tcp_seg_t     push_seg,
  output tcp_pkg::port_t        cb_loc_port,
  output tcp_pkg::port_t        cb_rem_port,
  output tcp_pkg::seq_t         cb_loc_seq,
  output tcp_pkg::seq_t         cb_rem_seq,
  output tcp_pkg::conn_status_t status
);
  import tcp_pkg::*;

  typedef enum logic [1:0] {
    close_none,
    close_active,
    close_passive,
    close_reset
  } close_t;

  typedef enum logic [3:0] {
    s_closed,
    s_listen,
    s_send_syn,
    s_syn_sent,
    s_send_ack,
    s_send_synack,
    s_synack_sent,
    s_established,
    s_dcn_send_fin,
    s_dcn_fin_sent,
    s_dcn_send_ack,
    s_dcn_send_rst
  } state_t;

  state_t state;
  close_t close;
  logic   last_ack_rec;  // peer acked our fin, waiting for its own
  logic   send_st;

  assign send_st = state inside {s_send_syn, s_send_ack, s_send_synack,
                                 s_dcn_send_fin, s_dcn_send_ack, s_dcn_send_rst};
  assign push    = send_st && !full;  // hold the send state while queue is full

  // handshakes in progress are bounded by the timer
  assign tmr_run = !(state inside {s_closed, s_listen, s_established});

  ///////////////////////////////////////////////////////////////////////
  // outgoing header, built from the control block
  ///////////////////////////////////////////////////////////////////////
  always_comb begin
    push_seg.src = cb_loc_port;
    push_seg.dst = cb_rem_port;
    push_seg.seq = cb_loc_seq;
    push_seg.ack = cb_rem_seq;
    case (state)
      s_send_syn     : push_seg.flags = FLAG_SYN;
      s_send_synack  : push_seg.flags = FLAG_SYN | FLAG_ACK;
      s_send_ack,
      s_dcn_send_ack : push_seg.flags = FLAG_ACK;
      s_dcn_send_fin : push_seg.flags = FLAG_FIN | FLAG_ACK;
      s_dcn_send_rst : push_seg.flags = FLAG_RST | FLAG_ACK;
      default        : push_seg.flags = '0;
    endcase
  end

  always_comb begin
    case (state)
      s_closed       : status = conn_closed;
      s_listen       : status = conn_listening;
      s_established  : status = conn_connected;
      s_dcn_send_fin,
      s_dcn_fin_sent,
      s_dcn_send_ack,
      s_dcn_send_rst : status = conn_disconnecting;
      default        : status = conn_connecting;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state        <= s_closed;
      close        <= close_none;
      last_ack_rec <= 1'b0;
    end else begin
      case (state)
        s_closed : begin
          close <= close_none;
          if (listen) begin  // passive open
            cb_loc_port <= loc_port;
            cb_loc_seq  <= isn;
            state       <= s_listen;
          end else if (connect) begin  // active open
            cb_loc_port <= loc_port;
            cb_rem_port <= rem_port;
            cb_loc_seq  <= isn;
            cb_rem_seq  <= '0;  // nothing to ack in the syn
            state       <= s_send_syn;
          end
        end
        s_listen : begin
          if (rx_evt.syn) begin
            cb_rem_port <= rx_seg.src;
            cb_rem_seq  <= rx_seg.seq + 32'd1;
            state       <= s_send_synack;
          end
        end
        s_send_syn,
        s_send_synack : begin
          if (push) begin
            cb_loc_seq <= cb_loc_seq + 32'd1;  // syn uses up one number
            state      <= (state == s_send_syn) ? s_syn_sent : s_synack_sent;
          end
        end
        s_syn_sent : begin
          if (rx_evt.syn_ack_ok) begin
            cb_rem_seq <= rx_seg.seq + 32'd1;
            state      <= s_send_ack;
          end
        end
        s_send_ack    : if (push) state <= s_established;
        s_synack_sent : if (rx_evt.ack_ok) state <= s_established;
        s_established : begin
          if (rx_evt.rst) begin
            close <= close_reset;
            state <= s_dcn_send_rst;
          end else if (rx_evt.fin) begin
            close      <= close_passive;
            cb_rem_seq <= rx_seg.seq + 32'd1;  // ack their fin
            state      <= s_dcn_send_ack;
          end else if (disconnect) begin
            close <= close_active;
            state <= s_dcn_send_fin;
          end
        end

        ///////////////////////////////////////////////////////////////////
        // closing
        ///////////////////////////////////////////////////////////////////
        s_dcn_send_fin : begin
          if (push) begin
            cb_loc_seq   <= cb_loc_seq + 32'd1;
            last_ack_rec <= 1'b0;
            state        <= s_dcn_fin_sent;
          end
        end
        s_dcn_fin_sent : begin
          if (close == close_passive) begin
            if (rx_evt.ack_any) state <= s_closed;  // last ack, done
          end else begin
            if (rx_evt.ack_any) last_ack_rec <= 1'b1;
            if (rx_evt.fin_ack && last_ack_rec) begin
              cb_rem_seq <= rx_seg.seq + 32'd1;
              state      <= s_dcn_send_ack;
            end
          end
        end
        s_dcn_send_ack : begin
          // passive side still owes its own fin
          if (push) state <= (close == close_passive) ? s_dcn_send_fin : s_closed;
        end
        s_dcn_send_rst : if (push) state <= s_closed;
        default        : state <= s_closed;
      endcase
      if (timeout) state <= s_closed;  // give up on a stuck handshake
    end
  end

endmodule : tcp_conn_ctrl

//--- src/tcp_seg_queue.sv
module tcp_seg_queue #(
  parameter int DEPTH = tcp_pkg::QUEUE_DEPTH_DEFAULT
) (
  input  logic              clk,
  input  logic              fsm_rst,
  input  logic              push,
  input  tcp_pkg::tcp_seg_t push_seg,
  input  logic              pop,
  output tcp_pkg::tcp_seg_t head_seg,
  output logic              full,
  output logic              empty
);
  import tcp_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  tcp_seg_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_seg;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_next(wr_ptr);
      if (pop)  rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10   : count <= count + 1'b1;
        2'b01   : count <= count - 1'b1;
        default : ;  // both or neither
      endcase
    end
  end

  assign head_seg = mem[rd_ptr];
  assign full     = (count == CW'(DEPTH));
  assign empty    = (count == '0);

  a_no_pop_empty : assert property (@(posedge clk) disable iff (fsm_rst) pop |-> !empty)
    else $error("pop from an empty segment queue");
  a_no_push_full : assert property (@(posedge clk) disable iff (fsm_rst) push |-> !full)
    else $error("push into a full segment queue");

endmodule : tcp_seg_queue

//--- src/tcp_tx_port.sv
module tcp_tx_port (
  input  logic              clk,
  input  logic              fsm_rst,
  input  tcp_pkg::tcp_seg_t head_seg,
  input  logic              empty,
  output logic              pop,
  output logic              tx_req,
  output tcp_pkg::tcp_seg_t tx_seg,
  input  logic              tx_ack
);

  typedef enum logic [1:0] {
    p_idle,  // nothing in flight
    p_req,   // tx_req high, waiting for tx_ack
    p_rel    // tx_req dropped, waiting for tx_ack low
  } port_st_t;

  port_st_t st;

  // idle takes the head at once, release waits for tx_ack low
  assign pop = !empty && ((st == p_idle) || (st == p_rel && !tx_ack));

  always_ff @(posedge clk) begin
    if (pop) tx_seg <= head_seg;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      st     <= p_idle;
      tx_req <= 1'b0;
    end else begin
      case (st)
        p_req : begin
          if (tx_ack) begin
            tx_req <= 1'b0;
            st     <= p_rel;
          end
        end
        default : begin
          if (pop) begin
            tx_req <= 1'b1;
            st     <= p_req;
          end else if (!tx_ack) begin
            st <= p_idle;
          end
        end
      endcase
    end
  end

  a_seg_stable : assert property (@(posedge clk) disable iff (fsm_rst)
    tx_req |=> (!tx_req || $stable(tx_seg)))
    else $error("tx_seg changed during a request");
  a_req_after_release : assert property (@(posedge clk) disable iff (fsm_rst)
    $rose(tx_req) |-> $past(!tx_ack))
    else $error("tx_req raised before tx_ack was released");

endmodule : tcp_tx_port

//--- src/tcp_conn_engine.sv
module tcp_conn_engine #(
  parameter int TIMEOUT_MS  = tcp_pkg::TIMEOUT_MS_DEFAULT,
  parameter int QUEUE_DEPTH = tcp_pkg::QUEUE_DEPTH_DEFAULT
) (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  tick_ms,
  input  logic                  listen,
  input  logic                  connect,
  input  logic                  disconnect,
  input  tcp_pkg::port_t        loc_port,
  input  tcp_pkg::port_t        rem_port,
  input  tcp_pkg::seq_t         isn,
  input  logic                  rx_val,
  input  tcp_pkg::tcp_seg_t     rx_seg,
  output logic                  tx_req,
  output tcp_pkg::tcp_seg_t     tx_seg,
  input  logic                  tx_ack,
  output tcp_pkg::conn_status_t status
);
  import tcp_pkg::*;

  rx_evt_t  rx_evt;
  port_t    cb_loc_port;
  port_t    cb_rem_port;
  seq_t     cb_loc_seq;
  seq_t     cb_rem_seq;
  logic     tmr_run;
  logic     timeout;
  logic     push;
  tcp_seg_t push_seg;
  logic     pop;
  tcp_seg_t head_seg;
  logic     full;
  logic     empty;

  tcp_rx_filter rx_filter_inst (
    .rx_val   (rx_val),
    .rx_seg   (rx_seg),
    .loc_port (cb_loc_port),
    .rem_port (cb_rem_port),
    .loc_seq  (cb_loc_seq),
    .rem_seq  (cb_rem_seq),
    .rx_evt   (rx_evt)
  );

  tcp_conn_ctrl conn_ctrl_inst (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .listen      (listen),
    .connect     (connect),
    .disconnect  (disconnect),
    .loc_port    (loc_port),
    .rem_port    (rem_port),
    .isn         (isn),
    .rx_seg      (rx_seg),
    .rx_evt      (rx_evt),
    .timeout     (timeout),
    .full        (full),
    .tmr_run     (tmr_run),
    .push        (push),
    .push_seg    (push_seg),
    .cb_loc_port (cb_loc_port),
    .cb_rem_port (cb_rem_port),
    .cb_loc_seq  (cb_loc_seq),
    .cb_rem_seq  (cb_rem_seq),
    .status      (status)
  );

  tcp_conn_timer #(.TIMEOUT_MS (TIMEOUT_MS)) conn_timer_inst (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .run     (tmr_run),
    .tick_ms (tick_ms),
    .timeout (timeout)
  );

  tcp_seg_queue #(.DEPTH (QUEUE_DEPTH)) seg_queue_inst (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .push     (push),
    .push_seg (push_seg),
    .pop      (pop),
    .head_seg (head_seg),
    .full     (full),
    .empty    (empty)
  );

  tcp_tx_port tx_port_inst (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .head_seg (head_seg),
    .empty    (empty),
    .pop      (pop),
    .tx_req   (tx_req),
    .tx_seg   (tx_seg),
    .tx_ack   (tx_ack)
  );

endmodule : tcp_conn_engine

//--- testbench/tb_clk_gen.sv
module tb_clk_gen #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;  // 50% duty
  end

endmodule : tb_clk_gen

//--- testbench/tb_tcp_conn_engine.sv
module tb_tcp_conn_engine;
  import tcp_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int STIM_DLY   = 1;   // drive and sample point after the rising edge
  localparam int TIMEOUT_MS = 20;
  localparam int N_ROUNDS   = 4;

  // cycle budget of each test, summed for the watchdog
  localparam int BUDGET_RESET   = 20;
  localparam int BUDGET_OPEN    = 300;  // each open test
  localparam int BUDGET_CLOSE   = 300;  // each close test
  localparam int BUDGET_RST     = 600;  // open plus reset
  localparam int BUDGET_TIMEOUT = 300;
  localparam int BUDGET_ROUND   = 700;
  localparam int BUDGET_TOTAL   = BUDGET_RESET + 2 * BUDGET_OPEN + 2 * BUDGET_CLOSE
                                  + BUDGET_RST + BUDGET_TIMEOUT + N_ROUNDS * BUDGET_ROUND;

  logic         clk;
  logic         fsm_rst;
  logic         tick_ms;
  logic         listen;
  logic         connect;
  logic         disconnect;
  port_t        loc_port;
  port_t        rem_port;
  seq_t         isn;
  logic         rx_val;
  tcp_seg_t     rx_seg;
  logic         tx_req;
  tcp_seg_t     tx_seg;
  logic         tx_ack;
  conn_status_t status;

  // peer model state and scoreboard
  port_t    m_loc_port;
  port_t    m_rem_port;
  seq_t     m_loc_seq;
  seq_t     m_rem_seq;
  tcp_seg_t exp_q[$];
  int       exp_cnt;
  int       got_cnt;
  int       checks;
  int       errors;
  string    test_name;

  tb_clk_gen #(.PERIOD (CLK_PERIOD)) clk_gen_inst (.clk (clk));

  tcp_conn_engine #(.TIMEOUT_MS (TIMEOUT_MS), .QUEUE_DEPTH (4)) UUT (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .tick_ms    (tick_ms),
    .listen     (listen),
    .connect    (connect),
    .disconnect (disconnect),
    .loc_port   (loc_port),
    .rem_port   (rem_port),
    .isn        (isn),
    .rx_val     (rx_val),
    .rx_seg     (rx_seg),
    .tx_req     (tx_req),
    .tx_seg     (tx_seg),
    .tx_ack     (tx_ack),
    .status     (status)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #STIM_DLY;
  endtask

  task automatic check(input string what, input logic [127:0] exp_v,
                       input logic [127:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  function automatic tcp_seg_t make_seg(port_t src_p, port_t dst_p, seq_t seq_n,
                                        seq_t ack_n, tcp_flags_t fl);
    tcp_seg_t s;
    s.src   = src_p;
    s.dst   = dst_p;
    s.seq   = seq_n;
    s.ack   = ack_n;
    s.flags = fl;
    return s;
  endfunction

  // header from the peer, one-cycle strobe
  task automatic send_seg(input port_t src_p, input port_t dst_p, input seq_t seq_n,
                          input seq_t ack_n, input tcp_flags_t fl);
    rx_seg = make_seg(src_p, dst_p, seq_n, ack_n, fl);
    rx_val = 1'b1;
    step();
    rx_val = 1'b0;
  endtask

  // engine to peer, always from the control block ports
  task automatic expect_seg(input seq_t seq_n, input seq_t ack_n, input tcp_flags_t fl);
    exp_q.push_back(make_seg(m_loc_port, m_rem_port, seq_n, ack_n, fl));
    exp_cnt++;
  endtask

  task automatic wait_segs(input int max_cycles);
    int n;
    int left;
    n = 0;
    @(posedge clk);  // peer pops at +STIM_DLY, so the edge sees a settled queue
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    left = exp_q.size();
    #STIM_DLY;
    if (left != 0) begin
      errors++;
      $display("%s: %0d expected segment(s) never sent within %0d cycles",
               test_name, left, max_cycles);
      exp_q.delete();
    end
  endtask

  task automatic wait_status(input conn_status_t want, input int max_cycles);
    int n;
    n = 0;
    while (status != want && n < max_cycles) begin
      step();
      n++;
    end
    check("status", 128'(want), 128'(status));
  endtask

  task automatic tick();
    tick_ms = 1'b1;
    step();
    tick_ms = 1'b0;
    step();
  endtask

  task automatic new_values();
    m_loc_port = port_t'($urandom);
    m_rem_port = port_t'($urandom);
    m_loc_seq  = $urandom;  // isn
    m_rem_seq  = '0;
    loc_port   = m_loc_port;
    rem_port   = m_rem_port;
    isn        = m_loc_seq;
  endtask

  //////////////////////////////////////////////////////////////////////
  // connection sequences
  //////////////////////////////////////////////////////////////////////

  // called in listening state
  task automatic passive_open();
    seq_t s;
    s = $urandom;
    send_seg(m_rem_port, m_loc_port, s, '0, FLAG_SYN);
    m_rem_seq = s + 32'd1;
    expect_seg(m_loc_seq, m_rem_seq, FLAG_SYN | FLAG_ACK);
    wait_segs(50);
    m_loc_seq = m_loc_seq + 32'd1;  // our syn counts as one
    send_seg(m_rem_port, m_loc_port, m_rem_seq, m_loc_seq, FLAG_ACK);
    wait_status(conn_connected, 10);
  endtask

  task automatic active_open();
    seq_t r;
    connect = 1'b1;
    step();
    connect = 1'b0;
    expect_seg(m_loc_seq, '0, FLAG_SYN);
    wait_segs(50);
    m_loc_seq = m_loc_seq + 32'd1;
    r = $urandom;
    send_seg(m_rem_port, m_loc_port, r, m_loc_seq, FLAG_SYN | FLAG_ACK);
    m_rem_seq = r + 32'd1;
    expect_seg(m_loc_seq, m_rem_seq, FLAG_ACK);
    wait_segs(50);
    wait_status(conn_connected, 10);
  endtask

  task automatic active_close();
    disconnect = 1'b1;
    step();
    disconnect = 1'b0;
    expect_seg(m_loc_seq, m_rem_seq, FLAG_FIN | FLAG_ACK);
    wait_segs(50);
    m_loc_seq = m_loc_seq + 32'd1;
    send_seg(m_rem_port, m_loc_port, m_rem_seq, m_loc_seq, FLAG_ACK);
    send_seg(m_rem_port, m_loc_port, m_rem_seq, m_loc_seq, FLAG_FIN | FLAG_ACK);
    m_rem_seq = m_rem_seq + 32'd1;  // ack the peer fin
    expect_seg(m_loc_seq, m_rem_seq, FLAG_ACK);
    wait_segs(50);
    wait_status(conn_closed, 10);
  endtask

  task automatic passive_close();
    send_seg(m_rem_port, m_loc_port, m_rem_seq, m_loc_seq, FLAG_FIN | FLAG_ACK);
    m_rem_seq = m_rem_seq + 32'd1;
    expect_seg(m_loc_seq, m_rem_seq, FLAG_ACK);
    expect_seg(m_loc_seq, m_rem_seq, FLAG_FIN | FLAG_ACK);
    wait_segs(80);
    check("status", 128'(conn_disconnecting), 128'(status));
    m_loc_seq = m_loc_seq + 32'd1;
    send_seg(m_rem_port, m_loc_port, m_rem_seq, m_loc_seq, FLAG_ACK);  // last ack
    wait_status(conn_closed, 10);
  endtask

  task automatic reset_close();
    send_seg(m_rem_port, m_loc_port, m_rem_seq, m_loc_seq, FLAG_RST);
    expect_seg(m_loc_seq, m_rem_seq, FLAG_RST | FLAG_ACK);
    wait_segs(50);
    wait_status(conn_closed, 10);
  endtask

  //////////////////////////////////////////////////////////////////////
  // peer side of the four-phase handshake
  //////////////////////////////////////////////////////////////////////
  initial begin : peer_model
    tcp_seg_t seg;
    int       delay;
    forever begin
      step();
      if (tx_req && !tx_ack) begin
        seg = tx_seg;
        got_cnt++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: engine sent an unexpected segment %h", test_name, seg);
        end else begin
          check($sformatf("segment %0d", got_cnt), 128'(exp_q.pop_front()), 128'(seg));
        end
        delay = int'($urandom % 7);  // back-pressure, 0 to 6 cycles
        repeat (delay) step();
        tx_ack = 1'b1;
        while (tx_req) step();
        tx_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(BUDGET_TOTAL * CLK_PERIOD);
    $display("watchdog: run did not finish within %0d cycles", BUDGET_TOTAL);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    int rnd;
    void'($urandom(32'h7a7a));
    fsm_rst    = 1'b1;
    tick_ms    = 1'b0;
    listen     = 1'b0;
    connect    = 1'b0;
    disconnect = 1'b0;
    loc_port   = '0;
    rem_port   = '0;
    isn        = '0;
    rx_val     = 1'b0;
    rx_seg     = '0;
    tx_ack     = 1'b0;
    exp_cnt    = 0;
    got_cnt    = 0;
    checks     = 0;
    errors     = 0;
    test_name  = "reset";
    repeat (5) @(posedge clk);
    #STIM_DLY;
    fsm_rst = 1'b0;
    check("status", 128'(conn_closed), 128'(status));
    check("tx_req", 128'(1'b0), 128'(tx_req));

    test_name = "passive_open";
    new_values();
    listen = 1'b1;
    step();
    listen = 1'b0;
    wait_status(conn_listening, 4);
    send_seg(m_rem_port, m_loc_port ^ 16'h0100, $urandom, '0, FLAG_SYN);  // wrong port
    repeat (20) step();
    wait_status(conn_listening, 0);
    passive_open();

    test_name = "active_close";
    active_close();

    test_name = "active_open";
    new_values();
    active_open();

    test_name = "passive_close";
    passive_close();

    test_name = "reset_close";
    new_values();
    active_open();
    reset_close();

    test_name = "timeout";
    new_values();
    connect = 1'b1;
    step();
    connect = 1'b0;
    expect_seg(m_loc_seq, '0, FLAG_SYN);
    wait_segs(50);
    repeat (TIMEOUT_MS - 1) tick();
    check("status", 128'(conn_connecting), 128'(status));
    tick();
    wait_status(conn_closed, 4);

    // mixed opens and closes under random ack delays
    test_name = "random_rounds";
    for (rnd = 0; rnd < N_ROUNDS; rnd++) begin
      new_values();
      if ($urandom % 2 == 0) begin
        listen = 1'b1;
        step();
        listen = 1'b0;
        wait_status(conn_listening, 4);
        passive_open();
      end else begin
        active_open();
      end
      case ($urandom % 3)
        0       : active_close();
        1       : passive_close();
        default : reset_close();
      endcase
    end

    test_name = "scoreboard";
    repeat (10) step();
    check("segments received", 128'(exp_cnt), 128'(got_cnt));

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_tcp_conn_engine

//--- project.f
src/tcp_pkg.sv
src/tcp_rx_filter.sv
src/tcp_conn_timer.sv
src/tcp_conn_ctrl.sv
src/tcp_seg_queue.sv
src/tcp_tx_port.sv
src/tcp_conn_engine.sv
testbench/tb_clk_gen.sv
testbench/tb_tcp_conn_engine.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log says so
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
  --top-module tb_tcp_conn_engine -o tb_tcp_conn_engine

./obj_dir/tb_tcp_conn_engine | tee sim.log

grep -qF '*** PASSED ***' sim.log
